/* build.f */
+incdir+include
+incdir+verification
rtl/rv_pkg.sv
rtl/reg_csr_file.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/result_unit.sv
rtl/rv_core.sv
verification/rv_core_tb.sv

/* include/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_SYSTEM      7'b1110011

`define ALU_ADD         4'd0
`define ALU_SUB         4'd1
`define ALU_SLT         4'd2
`define ALU_SLTU        4'd3
`define ALU_XOR         4'd4
`define ALU_OR          4'd5
`define ALU_AND         4'd6
`define ALU_SLL         4'd7
`define ALU_SRL         4'd8
`define ALU_SRA         4'd9
`define ALU_EQ          4'd10

`define OPA_REG         2'd0
`define OPA_PC          2'd1
`define OPA_ZERO        2'd2

`define OPB_REG         2'd0
`define OPB_IMM         2'd1
`define OPB_CSR         2'd2

`define IMM_I           3'd0
`define IMM_SH          3'd1
`define IMM_U           3'd2
`define IMM_J           3'd3
`define IMM_B           3'd4

`define CSR_MSTATUS     12'h300
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

`define CAUSE_ECALL     32'd11
`define RESET_PC        32'h0000_0000

`define INST_ECALL      32'h0000_0073
`define INST_MRET       32'h3020_0073

`endif

/* rtl/decode_unit.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module decode_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     inst,
    input  rv_pkg::word_t     pc,
    input  rv_pkg::word_t     rd_value,
    input  rv_pkg::word_t     csr_wdata,
    input  rv_pkg::word_t     mepc_wdata,
    output rv_pkg::word_t     pc_d,
    output rv_pkg::word_t     imm,
    output rv_pkg::word_t     rs1_value,
    output rv_pkg::word_t     rs2_value,
    output rv_pkg::word_t     csr_value,
    output rv_pkg::word_t     mtvec_value,
    output rv_pkg::word_t     mepc_value,
    output rv_pkg::word_t     a0_value,
    output rv_pkg::reg_addr_t rd_d,
    output rv_pkg::opa_sel_t  opa_sel,
    output rv_pkg::opb_sel_t  opb_sel,
    output rv_pkg::alu_op_t   alu_op,
    output logic              inv_flag,
    output logic              reg_wen_d,
    output logic              csr_set,
    output logic              jump_flag,
    output logic              branch_flag,
    output logic              ecall_flag,
    output logic              mret_flag,
    output logic              redirect,
    output rv_pkg::csr_wen_t  csr_wen_d
);
    import rv_pkg::*;

    word_t     inst_q;
    word_t     pc_q;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t rs1;
    reg_addr_t rs2;
    csr_addr_t csr_addr;
    imm_fmt_t  imm_fmt;
    logic      is_csr;

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? `ALU_SUB : `ALU_ADD;
            3'b001:  return `ALU_SLL;
            3'b010:  return `ALU_SLT;
            3'b011:  return `ALU_SLTU;
            3'b100:  return `ALU_XOR;
            3'b101:  return alt ? `ALU_SRA : `ALU_SRL;
            3'b110:  return `ALU_OR;
            default: return `ALU_AND;
        endcase
    endfunction

    // a redirect squashes the word fetched behind it.
    always_ff @(posedge clk) begin
        if (!rst_n || redirect) begin
            inst_q <= '0;
        end else begin
            inst_q <= inst;
        end
    end

    always_ff @(posedge clk) begin
        pc_q <= pc;
    end

    assign opcode   = inst_q[6:0];
    assign funct3   = inst_q[14:12];
    assign rs1      = inst_q[19:15];
    assign rs2      = inst_q[24:20];
    assign csr_addr = inst_q[31:20];
    assign rd_d     = inst_q[11:7];
    assign pc_d     = pc_q;

    always_comb begin
        case (imm_fmt)
            `IMM_SH: imm = {27'd0, inst_q[24:20]};
            `IMM_U:  imm = {inst_q[31:12], 12'd0};
            `IMM_J:  imm = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
            `IMM_B:  imm = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
            default: imm = {{20{inst_q[31]}}, inst_q[31:20]};
        endcase
    end

    always_comb begin
        opa_sel     = `OPA_REG;
        opb_sel     = `OPB_IMM;
        alu_op      = `ALU_ADD;
        imm_fmt     = `IMM_I;
        inv_flag    = 1'b0;
        reg_wen_d   = 1'b0;
        jump_flag   = 1'b0;
        branch_flag = 1'b0;
        case (opcode)
            `OPC_OP: begin
                opb_sel   = `OPB_REG;
                alu_op    = arith_op(funct3, inst_q[30]);
                reg_wen_d = 1'b1;
            end
            `OPC_OP_IMM: begin
                alu_op    = arith_op(funct3, inst_q[30] && funct3 == 3'b101);
                imm_fmt   = (funct3[1:0] == 2'b01) ? `IMM_SH : `IMM_I; // shift amount.
                reg_wen_d = 1'b1;
            end
            `OPC_LUI: begin
                opa_sel   = `OPA_ZERO;
                imm_fmt   = `IMM_U;
                reg_wen_d = 1'b1;
            end
            `OPC_AUIPC: begin
                opa_sel   = `OPA_PC;
                imm_fmt   = `IMM_U;
                reg_wen_d = 1'b1;
            end
            `OPC_JAL: begin
                opa_sel   = `OPA_PC;
                imm_fmt   = `IMM_J;
                jump_flag = 1'b1;
                reg_wen_d = 1'b1;
            end
            `OPC_JALR: begin
                jump_flag = 1'b1;
                reg_wen_d = 1'b1;
            end
            `OPC_BRANCH: begin
                opa_sel     = `OPA_PC;
                imm_fmt     = `IMM_B;
                branch_flag = 1'b1;
                inv_flag    = funct3[0]; // bne, bge, bgeu.
                alu_op      = funct3[2] ? (funct3[1] ? `ALU_SLTU : `ALU_SLT) : `ALU_EQ;
            end
            `OPC_SYSTEM: begin
                opa_sel   = `OPA_ZERO; // old csr value passes through the alu.
                opb_sel   = `OPB_CSR;
                reg_wen_d = 1'b1;
            end
            default: ;
        endcase
    end

    assign ecall_flag = (inst_q == `INST_ECALL);
    assign mret_flag  = (inst_q == `INST_MRET);
    assign is_csr     = (opcode == `OPC_SYSTEM) && (funct3 == 3'b001 || funct3 == 3'b010);
    assign csr_set    = is_csr && funct3[1];
    assign redirect   = jump_flag || branch_flag || ecall_flag || mret_flag;

    assign csr_wen_d[0] = (is_csr && csr_addr == `CSR_MEPC) || ecall_flag;
    assign csr_wen_d[1] = (is_csr && csr_addr == `CSR_MCAUSE) || ecall_flag;
    assign csr_wen_d[2] = is_csr && csr_addr == `CSR_MSTATUS;
    assign csr_wen_d[3] = is_csr && csr_addr == `CSR_MTVEC;

    reg_csr_file u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd_d),
        .rd_value    (rd_value),
        .reg_wen     (reg_wen_d),
        .csr_addr    (csr_addr),
        .csr_wen     (csr_wen_d),
        .csr_wdata   (csr_wdata),
        .mepc_wdata  (mepc_wdata),
        .ecall_flag  (ecall_flag),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .a0_value    (a0_value),
        .csr_value   (csr_value),
        .mtvec_value (mtvec_value),
        .mepc_value  (mepc_value)
    );

    // the slot behind a control transfer is a bubble that writes nothing.
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> inst_q == '0 && !reg_wen_d && csr_wen_d == '0 && !redirect);

endmodule

/* rtl/execute_unit.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module execute_unit (
    input  rv_pkg::word_t    pc_d,
    input  rv_pkg::word_t    rs1_value,
    input  rv_pkg::word_t    rs2_value,
    input  rv_pkg::word_t    imm,
    input  rv_pkg::word_t    csr_value,
    input  rv_pkg::opa_sel_t opa_sel,
    input  rv_pkg::opb_sel_t opb_sel,
    input  rv_pkg::alu_op_t  alu_op,
    input  logic             inv_flag,
    output rv_pkg::word_t    alu_result,
    output logic             cond
);
    import rv_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      cmp_b;
    word_t      sum;
    word_t      alu_out;
    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;
    logic       cmp_bit;

    always_comb begin
        case (opa_sel)
            `OPA_PC:   op_a = pc_d;
            `OPA_ZERO: op_a = '0;
            default:   op_a = rs1_value;
        endcase
        case (opb_sel)
            `OPB_REG: op_b = rs2_value;
            `OPB_CSR: op_b = csr_value;
            default:  op_b = imm;
        endcase
    end

    // pc-relative ops only add, so the comparator is free for rs1 against rs2.
    assign cmp_b = (opa_sel == `OPA_PC) ? rs2_value : op_b;
    assign eq    = (rs1_value == cmp_b);
    assign lt_s  = ($signed(rs1_value) < $signed(cmp_b));
    assign lt_u  = (rs1_value < cmp_b);
    assign sum   = op_a + op_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            `ALU_SUB:  alu_out = op_a - op_b;
            `ALU_SLT:  alu_out = {31'd0, lt_s};
            `ALU_SLTU: alu_out = {31'd0, lt_u};
            `ALU_XOR:  alu_out = op_a ^ op_b;
            `ALU_OR:   alu_out = op_a | op_b;
            `ALU_AND:  alu_out = op_a & op_b;
            `ALU_SLL:  alu_out = op_a << shamt;
            `ALU_SRL:  alu_out = op_a >> shamt;
            `ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
            default:   alu_out = sum;
        endcase
        case (alu_op)
            `ALU_EQ:   cmp_bit = eq;
            `ALU_SLT:  cmp_bit = lt_s;
            `ALU_SLTU: cmp_bit = lt_u;
            default:   cmp_bit = 1'b0;
        endcase
    end

    assign alu_result = (opa_sel == `OPA_PC) ? sum : alu_out; // targets and auipc.
    assign cond       = cmp_bit ^ inv_flag;

endmodule

/* rtl/reg_csr_file.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module reg_csr_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     rd_value,
    input  logic              reg_wen,
    input  rv_pkg::csr_addr_t csr_addr,
    input  rv_pkg::csr_wen_t  csr_wen,
    input  rv_pkg::word_t     csr_wdata,
    input  rv_pkg::word_t     mepc_wdata,
    input  logic              ecall_flag,
    output rv_pkg::word_t     rs1_value,
    output rv_pkg::word_t     rs2_value,
    output rv_pkg::word_t     a0_value,
    output rv_pkg::word_t     csr_value,
    output rv_pkg::word_t     mtvec_value,
    output rv_pkg::word_t     mepc_value
);
    import rv_pkg::*;

    word_t regs [31:1]; // x0 has no storage.
    word_t mstatus;
    word_t mtvec;
    word_t mepc;
    word_t mcause;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wen && rd != 5'd0) begin
            regs[rd] <= rd_value;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else begin
            if (ecall_flag) begin
                mepc   <= mepc_wdata; // trap entry takes precedence.
                mcause <= `CAUSE_ECALL;
            end else begin
                if (csr_wen[0]) mepc <= csr_wdata;
                if (csr_wen[1]) mcause <= csr_wdata;
            end
            if (csr_wen[2]) mstatus <= csr_wdata;
            if (csr_wen[3]) mtvec <= csr_wdata;
        end
    end

    assign rs1_value   = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value   = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign a0_value    = regs[10];
    assign mtvec_value = mtvec;
    assign mepc_value  = mepc;

    always_comb begin
        case (csr_addr)
            `CSR_MSTATUS: csr_value = mstatus;
            `CSR_MTVEC:   csr_value = mtvec;
            `CSR_MEPC:    csr_value = mepc;
            `CSR_MCAUSE:  csr_value = mcause;
            default:      csr_value = '0;
        endcase
    end

    // only a trap may write two csrs at once.
    assert property (@(posedge clk) disable iff (!rst_n) !ecall_flag |-> $onehot0(csr_wen));

endmodule

/* rtl/result_unit.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module result_unit (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::word_t pc_d,
    input  rv_pkg::word_t alu_result,
    input  rv_pkg::word_t csr_value,
    input  rv_pkg::word_t rs1_value,
    input  rv_pkg::word_t mtvec_value,
    input  rv_pkg::word_t mepc_value,
    input  logic          cond,
    input  logic          csr_set,
    input  logic          jump_flag,
    input  logic          branch_flag,
    input  logic          ecall_flag,
    input  logic          mret_flag,
    input  logic          redirect,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t rd_value,
    output rv_pkg::word_t csr_wdata,
    output rv_pkg::word_t mepc_wdata
);
    import rv_pkg::*;

    word_t link;
    word_t target;

    assign link       = pc_d + 32'd4;
    assign rd_value   = jump_flag ? link : alu_result; // csr reads arrive via the alu.
    assign csr_wdata  = csr_set ? (rs1_value | csr_value) : rs1_value;
    assign mepc_wdata = pc_d;

    always_comb begin
        if (ecall_flag) begin
            target = mtvec_value;
        end else if (mret_flag) begin
            target = mepc_value;
        end else if (branch_flag) begin
            target = cond ? alu_result : link;
        end else begin
            target = {alu_result[31:1], 1'b0}; // jalr drops bit 0.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= redirect ? target : pc + 32'd4;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::word_t inst,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t a0_value,
    output rv_pkg::word_t mepc_value
);
    import rv_pkg::*;

    word_t    pc_d;
    word_t    imm;
    word_t    rs1_value;
    word_t    rs2_value;
    word_t    csr_value;
    word_t    mtvec_value;
    word_t    alu_result;
    word_t    rd_value;
    word_t    csr_wdata;
    word_t    mepc_wdata;
    opa_sel_t opa_sel;
    opb_sel_t opb_sel;
    alu_op_t  alu_op;
    logic     inv_flag;
    logic     csr_set;
    logic     jump_flag;
    logic     branch_flag;
    logic     ecall_flag;
    logic     mret_flag;
    logic     redirect;
    logic     cond;

    // write-back index and enables stay inside decode.
    decode_unit u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst        (inst),
        .pc          (pc),
        .rd_value    (rd_value),
        .csr_wdata   (csr_wdata),
        .mepc_wdata  (mepc_wdata),
        .pc_d        (pc_d),
        .imm         (imm),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .csr_value   (csr_value),
        .mtvec_value (mtvec_value),
        .mepc_value  (mepc_value),
        .a0_value    (a0_value),
        .rd_d        (),
        .opa_sel     (opa_sel),
        .opb_sel     (opb_sel),
        .alu_op      (alu_op),
        .inv_flag    (inv_flag),
        .reg_wen_d   (),
        .csr_set     (csr_set),
        .jump_flag   (jump_flag),
        .branch_flag (branch_flag),
        .ecall_flag  (ecall_flag),
        .mret_flag   (mret_flag),
        .redirect    (redirect),
        .csr_wen_d   ()
    );

    execute_unit u_execute (
        .pc_d       (pc_d),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .imm        (imm),
        .csr_value  (csr_value),
        .opa_sel    (opa_sel),
        .opb_sel    (opb_sel),
        .alu_op     (alu_op),
        .inv_flag   (inv_flag),
        .alu_result (alu_result),
        .cond       (cond)
    );

    result_unit u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_d        (pc_d),
        .alu_result  (alu_result),
        .csr_value   (csr_value),
        .rs1_value   (rs1_value),
        .mtvec_value (mtvec_value),
        .mepc_value  (mepc_value),
        .cond        (cond),
        .csr_set     (csr_set),
        .jump_flag   (jump_flag),
        .branch_flag (branch_flag),
        .ecall_flag  (ecall_flag),
        .mret_flag   (mret_flag),
        .redirect    (redirect),
        .pc          (pc),
        .rd_value    (rd_value),
        .csr_wdata   (csr_wdata),
        .mepc_wdata  (mepc_wdata)
    );

endmodule

/* rtl/rv_pkg.sv */
package rv_pkg;

    // data, instruction and pc words.
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_addr_t;

    typedef logic [11:0] csr_addr_t;

    typedef logic [3:0] alu_op_t;

    // first and second alu operand sources.
    typedef logic [1:0] opa_sel_t;
    typedef logic [1:0] opb_sel_t;

    typedef logic [2:0] imm_fmt_t;

    // bit0 mepc, bit1 mcause, bit2 mstatus, bit3 mtvec.
    typedef logic [3:0] csr_wen_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module rv_core_tb -f build.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
exit 1

/* verification/rv_core_tests.svh */
`ifndef RV_CORE_TESTS_SVH
`define RV_CORE_TESTS_SVH

task automatic test_reset();
    open_test();
    emit(i_type(12'd0, 5'd0, 3'b000, 5'd7, `OPC_OP_IMM)); // addi x7, x0, 0.
    emit(NOP);
    emit(NOP);
    emit(NOP);
    self_loop();
    start_run();
    compare_word("pc", `RESET_PC, pc);
    compare_word("a0_value", 32'd0, a0_value);
    @(negedge clk);
    compare_word("pc", `RESET_PC + 32'd4, pc);
    compare_reg("rd_d", 5'd7, DUT.u_decode.rd_d);
    @(negedge clk);
    compare_word("pc", `RESET_PC + 32'd8, pc);
    wait_for_loop();
    compare_word("pc", loop_addr, pc);
    report_test("reset");
endtask

// result lands in x3 and is folded into a0.
task automatic alu_r(input logic [6:0] f7, input logic [2:0] f3, input word_t result);
    emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
    emit(r_type(7'h00, 5'd3, 5'd10, 3'b100, 5'd10));
    expected_a0 = expected_a0 ^ result;
endtask

task automatic alu_i(input logic [2:0] f3, input logic [11:0] field, input word_t result);
    emit(i_type(field, 5'd1, f3, 5'd3, `OPC_OP_IMM));
    emit(r_type(7'h00, 5'd3, 5'd10, 3'b100, 5'd10));
    expected_a0 = expected_a0 ^ result;
endtask

task automatic test_alu();
    word_t       a;
    word_t       b;
    word_t       rnd;
    word_t       imm_s;
    logic [11:0] imm;
    logic [4:0]  sh;
    open_test();
    a     = $urandom();
    b     = $urandom();
    rnd   = $urandom();
    imm   = rnd[11:0];
    sh    = rnd[16:12];
    imm_s = {{20{imm[11]}}, imm};
    load_constant(5'd1, a);
    load_constant(5'd2, b);
    alu_r(7'h00, 3'b000, a + b);
    alu_r(7'h20, 3'b000, a - b);
    alu_r(7'h00, 3'b001, a << b[4:0]);
    alu_r(7'h00, 3'b010, 32'($signed(a) < $signed(b)));
    alu_r(7'h00, 3'b011, 32'(a < b));
    alu_r(7'h00, 3'b100, a ^ b);
    alu_r(7'h00, 3'b101, a >> b[4:0]);
    alu_r(7'h20, 3'b101, $signed(a) >>> b[4:0]);
    alu_r(7'h00, 3'b110, a | b);
    alu_r(7'h00, 3'b111, a & b);
    alu_i(3'b000, imm, a + imm_s);
    alu_i(3'b010, imm, 32'($signed(a) < $signed(imm_s)));
    alu_i(3'b011, imm, 32'(a < imm_s));
    alu_i(3'b100, imm, a ^ imm_s);
    alu_i(3'b110, imm, a | imm_s);
    alu_i(3'b111, imm, a & imm_s);
    alu_i(3'b001, {7'h00, sh}, a << sh);
    alu_i(3'b101, {7'h00, sh}, a >> sh);
    alu_i(3'b101, {7'h20, sh}, $signed(a) >>> sh);
    emit(i_type(12'd5, 5'd1, 3'b000, 5'd0, `OPC_OP_IMM)); // addi x0, x1, 5.
    emit(r_type(7'h00, 5'd0, 5'd10, 3'b100, 5'd10));
    self_loop();
    start_run();
    wait_for_loop();
    compare_word("a0_value", expected_a0, a0_value);
    compare_word("pc", loop_addr, pc);
    report_test("alu");
endtask

function automatic logic branch_taken(input logic [2:0] f3, input word_t x, input word_t y);
    case (f3)
        3'b000:  return x == y;
        3'b001:  return x != y;
        3'b100:  return $signed(x) < $signed(y);
        3'b101:  return $signed(x) >= $signed(y);
        3'b110:  return x < y;
        default: return x >= y;
    endcase
endfunction

task automatic test_branches();
    logic [2:0] f3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      x;
    word_t      y;
    open_test();
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, `OPC_OP_IMM));
    emit(i_type(12'hffd, 5'd0, 3'b000, 5'd2, `OPC_OP_IMM)); // x2 = -3.
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd3, `OPC_OP_IMM));
    for (int k = 0; k < 6; k++) begin
        for (int p = 0; p < 3; p++) begin
            f3  = (k < 2) ? 3'(k) : 3'(k + 2);
            rs1 = (p == 2) ? 5'd2 : 5'd1;
            rs2 = (p == 0) ? 5'd3 : ((p == 1) ? 5'd2 : 5'd1);
            x   = (p == 2) ? 32'hffff_fffd : 32'd5;
            y   = (p == 1) ? 32'hffff_fffd : 32'd5;
            emit(i_type(12'd1, 5'd10, 3'b001, 5'd10, `OPC_OP_IMM)); // each case owns one bit.
            emit(branch_inst(13'd8, rs2, rs1, f3));
            emit(i_type(12'd1, 5'd10, 3'b000, 5'd10, `OPC_OP_IMM));
            expected_a0 = (expected_a0 << 1) + 32'(!branch_taken(f3, x, y));
        end
    end
    self_loop();
    start_run();
    wait_for_loop();
    compare_word("a0_value", expected_a0, a0_value);
    compare_word("pc", loop_addr, pc);
    report_test("branches");
endtask

task automatic test_jumps();
    word_t jal_pc;
    word_t jalr_pc;
    open_test();
    jal_pc = 32'(prog.size() * 4);
    emit(jal_inst(21'd12, 5'd1));
    emit(i_type(12'd1, 5'd10, 3'b000, 5'd10, `OPC_OP_IMM));
    emit(i_type(12'd2, 5'd10, 3'b000, 5'd10, `OPC_OP_IMM));
    emit(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd10));
    emit(i_type(12'd31, 5'd0, 3'b000, 5'd5, `OPC_OP_IMM));
    jalr_pc = 32'(prog.size() * 4);
    emit(i_type(12'd2, 5'd5, 3'b000, 5'd6, `OPC_JALR)); // odd target 33.
    emit(i_type(12'd64, 5'd10, 3'b000, 5'd10, `OPC_OP_IMM));
    emit(i_type(12'd128, 5'd10, 3'b000, 5'd10, `OPC_OP_IMM));
    emit(r_type(7'h00, 5'd6, 5'd10, 3'b000, 5'd10));
    self_loop();
    expected_a0 = (jal_pc + 32'd4) + (jalr_pc + 32'd4);
    start_run();
    wait_for_loop();
    compare_word("a0_value", expected_a0, a0_value);
    compare_word("pc", loop_addr, pc);
    report_test("jumps");
endtask

task automatic test_traps();
    word_t ecall_pc;
    open_test();
    emit(i_type(12'd64, 5'd0, 3'b000, 5'd1, `OPC_OP_IMM));
    emit(csr_inst(`CSR_MTVEC, 5'd1, 3'b001, 5'd0));
    emit(csr_inst(`CSR_MSTATUS, 5'd1, 3'b001, 5'd0)); // mstatus starts at 0x040.
    emit(i_type(12'h088, 5'd0, 3'b000, 5'd2, `OPC_OP_IMM));
    emit(csr_inst(`CSR_MSTATUS, 5'd2, 3'b010, 5'd0));
    emit(csr_inst(`CSR_MSTATUS, 5'd0, 3'b010, 5'd7)); // read back into x7.
    ecall_pc = 32'(prog.size() * 4);
    emit(`INST_ECALL);
    emit(i_type(12'h100, 5'd10, 3'b000, 5'd10, `OPC_OP_IMM));
    emit(r_type(7'h00, 5'd7, 5'd10, 3'b000, 5'd10));
    self_loop();
    pad_to(64);
    emit(csr_inst(`CSR_MCAUSE, 5'd0, 3'b010, 5'd10));
    emit(csr_inst(`CSR_MEPC, 5'd0, 3'b010, 5'd8));
    emit(i_type(12'd4, 5'd8, 3'b000, 5'd8, `OPC_OP_IMM));
    emit(csr_inst(`CSR_MEPC, 5'd8, 3'b001, 5'd0));
    emit(`INST_MRET);
    expected_a0 = `CAUSE_ECALL + 32'h100 + (32'h040 | 32'h088);
    start_run();
    while (pc !== 32'd64) @(negedge clk);
    compare_word("mepc_value", ecall_pc, mepc_value);
    wait_for_loop();
    compare_word("a0_value", expected_a0, a0_value);
    compare_word("mepc_value", ecall_pc + 32'd4, mepc_value);
    compare_word("pc", loop_addr, pc);
    report_test("traps");
endtask

`endif

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;
    import rv_pkg::*;

    localparam int    RESET_CYCLES = 10;
    localparam word_t NOP          = 32'h0000_0013; // addi x0, x0, 0.

    logic  clk;
    logic  rst_n;
    word_t inst;
    word_t pc;
    word_t a0_value;
    word_t mepc_value;

    word_t imem [0:255];
    word_t prog [$];
    word_t loop_addr;
    word_t expected_a0;
    int    cycle_count;
    int    cycle_limit;
    int    error_count;
    int    errors_before;
    int    test_count;
    int    failed_tests;
    int    seed_result;

    rv_core DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .pc         (pc),
        .a0_value   (a0_value),
        .mepc_value (mepc_value)
    );

    always #10 clk = ~clk;

    // instruction memory answers the pc on the falling edge.
    always @(negedge clk) begin
        inst <= imem[pc[9:2]];
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the program did not reach its final loop in %0d cycles",
                     cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %08h, actual %08h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_reg(input string name, input reg_addr_t expected,
                               input reg_addr_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %02h, actual %02h", name, expected, actual);
            error_count++;
        end
    endtask

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t jal_inst(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    function automatic word_t branch_inst(input logic [12:0] off, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic word_t csr_inst(input csr_addr_t csr, input reg_addr_t rs1,
                                       input logic [2:0] f3, input reg_addr_t rd);
        return i_type(csr, rs1, f3, rd, `OPC_SYSTEM);
    endfunction

    task automatic emit(input word_t word);
        prog.push_back(word);
    endtask

    task automatic pad_to(input int addr);
        while (prog.size() * 4 < addr) begin
            emit(NOP);
        end
    endtask

    task automatic self_loop();
        loop_addr = 32'(prog.size() * 4);
        emit(jal_inst(21'd0, 5'd0));
    endtask

    // lui takes the rounded upper part so that addi's sign extension cancels out.
    task automatic load_constant(input reg_addr_t rd, input word_t value);
        word_t hi;
        hi = value + 32'h800;
        emit(u_type(hi[31:12], rd, `OPC_LUI));
        emit(i_type(value[11:0], rd, 3'b000, rd, `OPC_OP_IMM));
    endtask

    task automatic open_test();
        prog.delete();
        expected_a0   = '0;
        errors_before = error_count;
    endtask

    task automatic start_run();
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : NOP;
        end
        cycle_limit = cycle_limit + 4 * prog.size() + RESET_CYCLES;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic wait_for_loop();
        while (pc !== loop_addr) @(negedge clk);
        repeat (4) @(negedge clk); // let the last write-backs land.
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s passed", name);
        end else begin
            failed_tests++;
            $display("test %s failed", name);
        end
    endtask

    `include "rv_core_tests.svh"

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst         = NOP;
        cycle_count  = 0;
        cycle_limit  = RESET_CYCLES;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        seed_result  = $urandom(32'hd340);
        for (int i = 0; i < 256; i++) begin
            imem[i] = NOP;
        end
        test_reset();
        test_alu();
        test_branches();
        test_jumps();
        test_traps();
        $display("%0d tests run, %0d failed, %0d failed checks",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
